// ==== verilog/dcore_pkg.sv ====
package dcore_pkg;

    ////////////////////////////////////////////////////////////
    // datapath and control sizes
    ////////////////////////////////////////////////////////////

    localparam int N_LANES     = 4;
    localparam int ADC_W       = 8;
    localparam int SYM_W       = 2;
    localparam int WORD_BITS   = N_LANES * SYM_W;
    localparam int N_PI        = 4;
    localparam int PI_W        = 9;
    localparam int MAX_SEL_W   = 5;
    localparam int PI_SCALE_SH = 4;
    localparam int CNT_W       = 32;
    localparam int VALID_WAIT  = 32;
    localparam int WAIT_CNT_W  = $clog2(VALID_WAIT);
    localparam int APB_AW      = 8;
    localparam int APB_DW      = 32;

    // x^7 + x^6 + 1
    localparam int PRBS_N   = 7;
    localparam int PRBS_TAP = 6;

    typedef logic signed [ADC_W-1:0]            adc_code_t;
    typedef logic [N_LANES*ADC_W-1:0]           adc_bus_t;
    typedef logic signed [ADC_W-1:0]            slice_lvl_t;
    typedef logic [N_LANES*SYM_W-1:0]           sym_bus_t;
    typedef logic [PI_W-1:0]                    pi_code_t;
    typedef logic [N_PI*PI_W-1:0]               pi_bus_t;
    typedef logic [N_PI*MAX_SEL_W-1:0]          max_sel_bus_t;
    typedef logic [CNT_W-1:0]                   cnt_t;
    typedef logic [APB_AW-1:0]                  apb_addr_t;

    typedef enum logic [1:0] {
        PRBS_IDLE  = 2'd0,
        PRBS_SEED  = 2'd1,
        PRBS_CHECK = 2'd2
    } prbs_state_t;

    // gray coded pam4 levels
    localparam logic [SYM_W-1:0] SYM_P3 = 2'b10;
    localparam logic [SYM_W-1:0] SYM_P1 = 2'b11;
    localparam logic [SYM_W-1:0] SYM_M1 = 2'b01;
    localparam logic [SYM_W-1:0] SYM_M3 = 2'b00;

    ////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////

    localparam apb_addr_t REG_CTRL       = 8'h00;
    localparam apb_addr_t REG_SLICE      = 8'h04;
    localparam apb_addr_t REG_PI_MAX_SEL = 8'h08;
    localparam apb_addr_t REG_PI_OFF_01  = 8'h0C;
    localparam apb_addr_t REG_PI_OFF_23  = 8'h10;
    localparam apb_addr_t REG_PRBS_ERR   = 8'h14;
    localparam apb_addr_t REG_PRBS_TOTAL = 8'h18;
    localparam apb_addr_t REG_STATUS     = 8'h1C;

    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_CLR_BIT = 1;

    localparam logic [MAX_SEL_W-1:0] MAX_SEL_RST = '1;

endpackage

// ==== verilog/dcore_regs.sv ====
`timescale 1ns/100ps

module dcore_regs import dcore_pkg::*; (
    input  logic              clk_adc,
    input  logic              cdr_rstb,

    // apb slave
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  apb_addr_t         paddr_i,
    input  logic [APB_DW-1:0] pwdata_i,
    output logic [APB_DW-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,

    // status from the datapath
    input  cnt_t              prbs_err_i,
    input  cnt_t              prbs_total_i,
    input  logic              prbs_locked_i,
    input  logic              ctl_valid_i,

    // settings to the datapath
    output slice_lvl_t        slice_low_o,
    output slice_lvl_t        slice_mid_o,
    output slice_lvl_t        slice_high_o,
    output logic              prbs_en_o,
    output logic              prbs_clear_o,
    output max_sel_bus_t      pi_max_sel_o,
    output pi_bus_t           pi_offset_o
);

    logic              access;
    logic              addr_hit;
    logic              wr_en;
    logic [APB_DW-1:0] rd_data;

    logic              prbs_en_q;
    logic              prbs_clear_q;
    slice_lvl_t        slice_low_q;
    slice_lvl_t        slice_mid_q;
    slice_lvl_t        slice_high_q;
    max_sel_bus_t      max_sel_q;
    pi_bus_t           offset_q;

    // access phase of a zero-wait transfer
    assign access = psel_i & penable_i;
    assign wr_en  = access & pwrite_i & addr_hit;

    ////////////////////////////////////////////////////////////
    // decode and read-back
    ////////////////////////////////////////////////////////////

    always_comb begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (paddr_i)
            REG_CTRL: begin
                rd_data[CTRL_EN_BIT] = prbs_en_q;
            end
            REG_SLICE: begin
                rd_data[3*ADC_W-1:0] = {slice_high_q, slice_mid_q, slice_low_q};
            end
            REG_PI_MAX_SEL: begin
                rd_data[N_PI*MAX_SEL_W-1:0] = max_sel_q;
            end
            REG_PI_OFF_01: begin
                rd_data[0 +: PI_W]  = offset_q[0 +: PI_W];
                rd_data[16 +: PI_W] = offset_q[PI_W +: PI_W];
            end
            REG_PI_OFF_23: begin
                rd_data[0 +: PI_W]  = offset_q[2*PI_W +: PI_W];
                rd_data[16 +: PI_W] = offset_q[3*PI_W +: PI_W];
            end
            REG_PRBS_ERR:   rd_data = prbs_err_i;
            REG_PRBS_TOTAL: rd_data = prbs_total_i;
            REG_STATUS: begin
                rd_data[1:0] = {prbs_locked_i, ctl_valid_i};
            end
            default: addr_hit = 1'b0;
        endcase
    end

    assign prdata_o  = (access && !pwrite_i) ? rd_data : '0;
    assign pslverr_o = access & ~addr_hit;
    assign pready_o  = 1'b1;

    ////////////////////////////////////////////////////////////
    // writable settings
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            prbs_en_q    <= 1'b0;
            prbs_clear_q <= 1'b0;
            slice_low_q  <= '0;
            slice_mid_q  <= '0;
            slice_high_q <= '0;
            max_sel_q    <= {N_PI{MAX_SEL_RST}};
            offset_q     <= '0;
        end else begin
            // write-one clear, high for one cycle only
            prbs_clear_q <= wr_en && (paddr_i == REG_CTRL) && pwdata_i[CTRL_CLR_BIT];
            if (wr_en) begin
                case (paddr_i)
                    REG_CTRL: prbs_en_q <= pwdata_i[CTRL_EN_BIT];
                    REG_SLICE: begin
                        slice_low_q  <= pwdata_i[0 +: ADC_W];
                        slice_mid_q  <= pwdata_i[ADC_W +: ADC_W];
                        slice_high_q <= pwdata_i[2*ADC_W +: ADC_W];
                    end
                    REG_PI_MAX_SEL: max_sel_q <= pwdata_i[N_PI*MAX_SEL_W-1:0];
                    REG_PI_OFF_01: begin
                        offset_q[0 +: PI_W]    <= pwdata_i[0 +: PI_W];
                        offset_q[PI_W +: PI_W] <= pwdata_i[16 +: PI_W];
                    end
                    REG_PI_OFF_23: begin
                        offset_q[2*PI_W +: PI_W] <= pwdata_i[0 +: PI_W];
                        offset_q[3*PI_W +: PI_W] <= pwdata_i[16 +: PI_W];
                    end
                    default: ;
                endcase
            end
        end
    end

    assign slice_low_o  = slice_low_q;
    assign slice_mid_o  = slice_mid_q;
    assign slice_high_o = slice_high_q;
    assign prbs_en_o    = prbs_en_q;
    assign prbs_clear_o = prbs_clear_q;
    assign pi_max_sel_o = max_sel_q;
    assign pi_offset_o  = offset_q;

endmodule

// ==== verilog/pam4_slicer.sv ====
`timescale 1ns/100ps

module pam4_slicer import dcore_pkg::*; (
    input  logic       clk_adc,
    input  logic       cdr_rstb,
    input  adc_bus_t   adc_codes_i,
    input  slice_lvl_t slice_low_i,
    input  slice_lvl_t slice_mid_i,
    input  slice_lvl_t slice_high_i,
    output sym_bus_t   syms_o
);

    sym_bus_t syms_d;

    // signed three-level decision, gray mapped
    function automatic logic [SYM_W-1:0] slice_sym(
        input adc_code_t  code,
        input slice_lvl_t lvl_lo,
        input slice_lvl_t lvl_mid,
        input slice_lvl_t lvl_hi
    );
        if (code > lvl_hi) begin
            return SYM_P3;
        end else if (code > lvl_mid) begin
            return SYM_P1;
        end else if (code > lvl_lo) begin
            return SYM_M1;
        end
        return SYM_M3;
    endfunction

    for (genvar l = 0; l < N_LANES; l++) begin : g_lane
        assign syms_d[l*SYM_W +: SYM_W] = slice_sym(
            adc_code_t'(adc_codes_i[l*ADC_W +: ADC_W]),
            slice_low_i,
            slice_mid_i,
            slice_high_i
        );
    end

    // one cycle from codes to symbols
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            syms_o <= '0;
        end else begin
            syms_o <= syms_d;
        end
    end

endmodule

// ==== verilog/sym_prbs_checker.sv ====
`timescale 1ns/100ps

module sym_prbs_checker import dcore_pkg::*; (
    input  logic     clk_adc,
    input  logic     cdr_rstb,
    input  sym_bus_t syms_i,
    input  logic     prbs_en_i,
    input  logic     prbs_clear_i,
    output cnt_t     err_cnt_o,
    output cnt_t     total_cnt_o,
    output logic     locked_o
);

    prbs_state_t                      state_q;
    logic [PRBS_N-1:0]                hist_q;
    logic [PRBS_N-1:0]                hist_nxt;
    logic [$clog2(WORD_BITS+1)-1:0]   word_errs;
    logic                             rx_bit;
    cnt_t                             err_q;
    cnt_t                             total_q;

    ////////////////////////////////////////////////////////////
    // self-synchronizing check over one word
    ////////////////////////////////////////////////////////////

    // hist[0] is the newest bit, hist[PRBS_N-1] the oldest
    always_comb begin
        hist_nxt  = hist_q;
        word_errs = '0;
        rx_bit    = 1'b0;
        for (int t = 0; t < WORD_BITS; t++) begin
            // lane t/2 in time order, msb first
            rx_bit = syms_i[SYM_W*(t/SYM_W) + (SYM_W-1) - (t%SYM_W)];
            if (rx_bit != (hist_nxt[PRBS_N-1] ^ hist_nxt[PRBS_TAP-1])) begin
                word_errs = word_errs + 1'b1;
            end
            hist_nxt = {hist_nxt[PRBS_N-2:0], rx_bit};
        end
    end

    // history follows the received stream
    always_ff @(posedge clk_adc) begin
        if (state_q != PRBS_IDLE) begin
            hist_q <= hist_nxt;
        end
    end

    ////////////////////////////////////////////////////////////
    // state and counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state_q <= PRBS_IDLE;
            err_q   <= '0;
            total_q <= '0;
        end else begin
            if (prbs_clear_i) begin
                err_q   <= '0;
                total_q <= '0;
            end else if (prbs_en_i && state_q == PRBS_CHECK) begin
                err_q   <= err_q + cnt_t'(word_errs);
                total_q <= total_q + cnt_t'(WORD_BITS);
            end

            // counters hold while disabled
            if (!prbs_en_i) begin
                state_q <= PRBS_IDLE;
            end else if (prbs_clear_i) begin
                state_q <= PRBS_SEED;
            end else begin
                case (state_q)
                    PRBS_IDLE: state_q <= PRBS_SEED;
                    PRBS_SEED: state_q <= PRBS_CHECK;
                    default:   state_q <= PRBS_CHECK;
                endcase
            end
        end
    end

    assign err_cnt_o   = err_q;
    assign total_cnt_o = total_q;
    assign locked_o    = (state_q == PRBS_CHECK);

endmodule

// ==== verilog/pi_ctl_mapper.sv ====
`timescale 1ns/100ps

module pi_ctl_mapper import dcore_pkg::*; (
    input  logic         clk_adc,
    input  logic         cdr_rstb,
    input  pi_bus_t      pi_ctl_i,
    input  max_sel_bus_t pi_max_sel_i,
    input  pi_bus_t      pi_offset_i,
    output pi_bus_t      pi_ctl_o,
    output logic         ctl_valid_o
);

    logic [WAIT_CNT_W-1:0] wait_cnt_q;
    logic                  ctl_valid_q;

    ////////////////////////////////////////////////////////////
    // per-output scale and offset
    ////////////////////////////////////////////////////////////

    for (genvar j = 0; j < N_PI; j++) begin : g_pi
        logic [PI_W:0] sel_ext;
        pi_code_t      scale;
        pi_code_t      code_mod;
        pi_code_t      pi_q;

        // (sel + 1) * 16 - 1, never below 15
        assign sel_ext  = (PI_W+1)'(pi_max_sel_i[j*MAX_SEL_W +: MAX_SEL_W]);
        assign scale    = pi_code_t'(((sel_ext + 1'b1) << PI_SCALE_SH) - 1'b1);
        assign code_mod = pi_ctl_i[j*PI_W +: PI_W] % scale;

        // wraps modulo 2^PI_W
        always_ff @(posedge clk_adc or negedge cdr_rstb) begin
            if (!cdr_rstb) begin
                pi_q <= '0;
            end else begin
                pi_q <= code_mod + pi_offset_i[j*PI_W +: PI_W];
            end
        end

        assign pi_ctl_o[j*PI_W +: PI_W] = pi_q;
    end

    ////////////////////////////////////////////////////////////
    // valid after the post-reset wait
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            wait_cnt_q  <= '0;
            ctl_valid_q <= 1'b0;
        end else begin
            if (wait_cnt_q != WAIT_CNT_W'(VALID_WAIT - 1)) begin
                wait_cnt_q <= wait_cnt_q + 1'b1;
            end
            // counter full after edge 31, so valid rises on edge 32
            ctl_valid_q <= (wait_cnt_q == WAIT_CNT_W'(VALID_WAIT - 1));
        end
    end

    assign ctl_valid_o = ctl_valid_q;

endmodule

// ==== verilog/digital_core.sv ====
`timescale 1ns/100ps

module digital_core import dcore_pkg::*; (
    input  logic              clk_adc,
    input  logic              cdr_rstb,

    // apb
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  apb_addr_t         paddr_i,
    input  logic [APB_DW-1:0] pwdata_i,
    output logic [APB_DW-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,

    // datapath
    input  adc_bus_t          adc_codes_i,
    input  pi_bus_t           pi_ctl_i,
    output pi_bus_t           pi_ctl_o,
    output logic              ctl_valid_o
);

    slice_lvl_t   slice_low;
    slice_lvl_t   slice_mid;
    slice_lvl_t   slice_high;
    logic         prbs_en;
    logic         prbs_clear;
    max_sel_bus_t pi_max_sel;
    pi_bus_t      pi_offset;
    sym_bus_t     syms;
    cnt_t         prbs_err;
    cnt_t         prbs_total;
    logic         prbs_locked;

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    dcore_regs regs_inst (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .prbs_err_i    (prbs_err),
        .prbs_total_i  (prbs_total),
        .prbs_locked_i (prbs_locked),
        .ctl_valid_i   (ctl_valid_o),
        .slice_low_o   (slice_low),
        .slice_mid_o   (slice_mid),
        .slice_high_o  (slice_high),
        .prbs_en_o     (prbs_en),
        .prbs_clear_o  (prbs_clear),
        .pi_max_sel_o  (pi_max_sel),
        .pi_offset_o   (pi_offset)
    );

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////

    pam4_slicer slicer_inst (
        .clk_adc      (clk_adc),
        .cdr_rstb     (cdr_rstb),
        .adc_codes_i  (adc_codes_i),
        .slice_low_i  (slice_low),
        .slice_mid_i  (slice_mid),
        .slice_high_i (slice_high),
        .syms_o       (syms)
    );

    // raw slicer symbols only
    sym_prbs_checker prbs_checker_inst (
        .clk_adc      (clk_adc),
        .cdr_rstb     (cdr_rstb),
        .syms_i       (syms),
        .prbs_en_i    (prbs_en),
        .prbs_clear_i (prbs_clear),
        .err_cnt_o    (prbs_err),
        .total_cnt_o  (prbs_total),
        .locked_o     (prbs_locked)
    );

    pi_ctl_mapper pi_mapper_inst (
        .clk_adc      (clk_adc),
        .cdr_rstb     (cdr_rstb),
        .pi_ctl_i     (pi_ctl_i),
        .pi_max_sel_i (pi_max_sel),
        .pi_offset_i  (pi_offset),
        .pi_ctl_o     (pi_ctl_o),
        .ctl_valid_o  (ctl_valid_o)
    );

endmodule

// ==== dv/digital_core_chk.sv ====
`timescale 1ns/100ps

module digital_core_chk (
    input logic clk_adc,
    input logic cdr_rstb,
    input logic psel_i,
    input logic penable_i,
    input logic pready_o,
    input logic pslverr_o,
    input logic ctl_valid_o
);

    ////////////////////////////////////////////////////////////
    // apb slave rules
    ////////////////////////////////////////////////////////////

    // zero wait states
    a_pready_high: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb) pready_o
    ) else $error("pready_o dropped low");

    // slave error only in the access phase
    a_slverr_access: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb) pslverr_o |-> (psel_i && penable_i)
    ) else $error("pslverr_o high outside an access phase");

    ////////////////////////////////////////////////////////////
    // valid timer
    ////////////////////////////////////////////////////////////

    // sticky once set
    a_valid_sticky: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb) !$fell(ctl_valid_o)
    ) else $error("ctl_valid_o fell while out of reset");

endmodule

// ==== dv/tb_digital_core.sv ====
`timescale 1ns/100ps

module tb_digital_core;
    import dcore_pkg::*;

    localparam int          N_WORDS       = 32;
    localparam int          N_PI_VEC      = 24;
    localparam int          APB_CYC       = 3 * 40;
    localparam int          MAX_CYC       = 2 * N_WORDS + APB_CYC + N_PI_VEC + VALID_WAIT + 200;
    localparam apb_addr_t   ADDR_UNMAPPED = 8'h20;
    localparam logic [31:0] SLICE_SET     = 32'h0040_00C0;

    logic              clk_adc;
    logic              cdr_rstb;
    logic              psel_i;
    logic              penable_i;
    logic              pwrite_i;
    apb_addr_t         paddr_i;
    logic [APB_DW-1:0] pwdata_i;
    logic [APB_DW-1:0] prdata_o;
    logic              pready_o;
    logic              pslverr_o;
    adc_bus_t          adc_codes_i;
    pi_bus_t           pi_ctl_i;
    pi_bus_t           pi_ctl_o;
    logic              ctl_valid_o;

    logic [39:0]       pat_mem [0:N_WORDS-1];
    logic [7:0]        model_syms [0:N_WORDS-1];
    int                value_errs;
    int                other_errs;
    int                cyc_cnt;

    digital_core digital_core_inst (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .adc_codes_i (adc_codes_i),
        .pi_ctl_i    (pi_ctl_i),
        .pi_ctl_o    (pi_ctl_o),
        .ctl_valid_o (ctl_valid_o)
    );

    bind digital_core digital_core_chk chk_inst (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .ctl_valid_o (ctl_valid_o)
    );

    initial begin
        clk_adc = 1'b0;
        forever #2 clk_adc = ~clk_adc;
    end

    // run limit
    always @(posedge clk_adc) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= MAX_CYC) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYC);
            $display(">>> FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        value_errs++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        other_errs++;
    endtask

    // called 1 ns after an edge, returns 1 ns after the write edge
    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data,
                             output logic err);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b1;
        paddr_i   = addr;
        pwdata_i  = data;
        @(posedge clk_adc);
        #1 penable_i = 1'b1;
        #1 err = pslverr_o;
        @(posedge clk_adc);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data,
                            output logic err);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = addr;
        @(posedge clk_adc);
        #1 penable_i = 1'b1;
        #1;
        data = prdata_o;
        err  = pslverr_o;
        @(posedge clk_adc);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic check_reg(input string name, input apb_addr_t addr, input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        if (err) report_error({"unexpected slave error reading ", name});
        if (data !== exp) report_mismatch(name, exp, data);
    endtask

    // thresholds at -64, 0 and +64
    function automatic logic [1:0] slice_rule(input logic signed [7:0] code);
        if (code > 8'sd64) return 2'b10;
        if (code > 8'sd0) return 2'b11;
        if (code > -8'sd64) return 2'b01;
        return 2'b00;
    endfunction

    function automatic logic [8:0] pi_expect(input logic [8:0] code, input logic [4:0] sel,
                                             input logic [8:0] off);
        int scale;
        int v;
        scale = (int'(sel) + 1) * 16 - 1;
        v = (int'(code) % scale + int'(off)) % 512;
        return v[8:0];
    endfunction

    // word 0 seeds, every later bit must equal b[n-7] ^ b[n-6]
    function automatic int prbs_expect_errs();
        logic bits [0:8*N_WORDS-1];
        int   errs;
        errs = 0;
        for (int k = 0; k < N_WORDS; k++) begin
            for (int l = 0; l < 4; l++) begin
                bits[8*k + 2*l]     = model_syms[k][2*l+1];
                bits[8*k + 2*l + 1] = model_syms[k][2*l];
            end
        end
        for (int n = 8; n < 8 * N_WORDS; n++) begin
            if (bits[n] != (bits[n-7] ^ bits[n-6])) errs++;
        end
        return errs;
    endfunction

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [31:0] slice_val;
        logic [31:0] sel_val;
        logic [31:0] off01;
        logic [31:0] off23;
        pi_bus_t     pi_in;
        logic [8:0]  pi_exp;
        int          exp_errs;

        rd = $urandom(32'he778_1258);
        value_errs  = 0;
        other_errs  = 0;
        cdr_rstb    = 1'b0;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        paddr_i     = '0;
        pwdata_i    = '0;
        adc_codes_i = '0;
        pi_ctl_i    = '0;
        $readmemh("dv/prbs_patterns.txt", pat_mem);

        repeat (2) @(posedge clk_adc);
        #1 cdr_rstb = 1'b1;

        // reset values and the valid timer
        if (pi_ctl_o !== '0) report_mismatch("reset pi_ctl_o", 0, pi_ctl_o);
        if (ctl_valid_o !== 1'b0) report_mismatch("reset ctl_valid_o", 0, ctl_valid_o);
        repeat (VALID_WAIT - 1) @(posedge clk_adc);
        #1;
        if (ctl_valid_o !== 1'b0) report_mismatch("ctl_valid_o at edge 31", 0, ctl_valid_o);
        @(posedge clk_adc);
        #1;
        if (ctl_valid_o !== 1'b1) report_mismatch("ctl_valid_o at edge 32", 1, ctl_valid_o);
        apb_read(REG_STATUS, rd, err);
        if (rd[0] !== 1'b1) report_mismatch("status ctl_valid", 1, rd[0]);

        // register read-back
        slice_val = $urandom & 32'h00FF_FFFF;
        sel_val   = $urandom & 32'h000F_FFFF;
        off01     = $urandom & 32'h01FF_01FF;
        off23     = $urandom & 32'h01FF_01FF;
        apb_write(REG_SLICE, slice_val, err);
        apb_write(REG_PI_MAX_SEL, sel_val, err);
        apb_write(REG_PI_OFF_01, off01, err);
        apb_write(REG_PI_OFF_23, off23, err);
        check_reg("slice", REG_SLICE, slice_val);
        check_reg("pi_max_sel", REG_PI_MAX_SEL, sel_val);
        check_reg("pi_off_01", REG_PI_OFF_01, off01);
        check_reg("pi_off_23", REG_PI_OFF_23, off23);

        apb_write(ADDR_UNMAPPED, $urandom, err);
        if (!err) report_error("write to an unmapped address gave no slave error");
        apb_read(ADDR_UNMAPPED, rd, err);
        if (!err) report_error("read of an unmapped address gave no slave error");
        if (rd !== 32'h0) report_mismatch("unmapped read data", 0, rd);
        check_reg("slice after unmapped write", REG_SLICE, slice_val);
        check_reg("pi_max_sel after unmapped write", REG_PI_MAX_SEL, sel_val);
        check_reg("pi_off_01 after unmapped write", REG_PI_OFF_01, off01);
        check_reg("pi_off_23 after unmapped write", REG_PI_OFF_23, off23);

        // pi mapping with the random settings above
        for (int i = 0; i < N_PI_VEC; i++) begin
            pi_in    = pi_bus_t'({$urandom, $urandom});
            pi_ctl_i = pi_in;
            @(posedge clk_adc);
            #1;
            for (int j = 0; j < N_PI; j++) begin
                pi_exp = pi_expect(pi_in[j*PI_W +: PI_W], sel_val[j*MAX_SEL_W +: MAX_SEL_W],
                                   (j % 2 == 0) ? off01[8:0] : off01[24:16]);
                if (j >= 2) begin
                    pi_exp = pi_expect(pi_in[j*PI_W +: PI_W],
                                       sel_val[j*MAX_SEL_W +: MAX_SEL_W],
                                       (j % 2 == 0) ? off23[8:0] : off23[24:16]);
                end
                if (pi_ctl_o[j*PI_W +: PI_W] !== pi_exp) begin
                    report_mismatch($sformatf("pi_ctl_o[%0d]", j), pi_exp,
                                    pi_ctl_o[j*PI_W +: PI_W]);
                end
            end
        end

        ////////////////////////////////////////////////////////////
        // slicing and prbs counting
        ////////////////////////////////////////////////////////////

        apb_write(REG_SLICE, SLICE_SET, err);
        apb_write(REG_CTRL, 32'h1, err);
        // word 0 reaches the checker in its seed cycle
        for (int k = 0; k < N_WORDS; k++) begin
            adc_codes_i = pat_mem[k][39:8];
            for (int l = 0; l < N_LANES; l++) begin
                model_syms[k][2*l +: 2] = slice_rule(pat_mem[k][8 + 8*l +: 8]);
            end
            if (model_syms[k] !== pat_mem[k][7:0]) begin
                report_mismatch($sformatf("pattern word %0d symbols", k),
                                pat_mem[k][7:0], model_syms[k]);
            end
            if (k < N_WORDS - 1) begin
                @(posedge clk_adc);
                #1;
                if (digital_core_inst.syms !== model_syms[k]) begin
                    report_mismatch($sformatf("slicer word %0d", k), model_syms[k],
                                    digital_core_inst.syms);
                end
            end
        end
        // disable lands right after the last word is counted
        apb_write(REG_CTRL, 32'h0, err);
        if (digital_core_inst.syms !== model_syms[N_WORDS-1]) begin
            report_mismatch("slicer last word", model_syms[N_WORDS-1], digital_core_inst.syms);
        end
        exp_errs = prbs_expect_errs();
        check_reg("prbs_err", REG_PRBS_ERR, exp_errs);
        check_reg("prbs_total", REG_PRBS_TOTAL, 8 * (N_WORDS - 1));

        // locked two edges after enable
        apb_write(REG_CTRL, 32'h1, err);
        @(posedge clk_adc);
        #1;
        apb_read(REG_STATUS, rd, err);
        if (rd[1] !== 1'b1) report_mismatch("status prbs_locked", 1, rd[1]);

        // clear and disable together
        apb_write(REG_CTRL, 32'h2, err);
        check_reg("prbs_err after clear", REG_PRBS_ERR, 32'h0);
        check_reg("prbs_total after clear", REG_PRBS_TOTAL, 32'h0);

        $display("value mismatches: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/prbs_patterns.txt ====
// one word per cycle: lane3 lane2 lane1 lane0 codes, then expected symbol byte
// prbs7 stream for slice levels -64 / 0 / +64, bit errors in words 26 and 29
60202020BF
A0E0A0A010
A060E0A024
E0A0E0E045
A0E060201B
E060E0E065
A0E0E02017
60602020AF
A020E0A034
E060A0E061
E0E020605E
E02020607E
E020A06072
602060A0B8
60E060209B
E0E0E0E055
A02020203F
A060A0A020
A0A020A00C
20A06060CA
A060A02023
20A02060CE
E06060606A
A0E020201F
A06020A02C
20A0E060C6
20606020EB
206020E0ED
6060E0A0A4
E020A0E071
A020A02033
20606060EA

// ==== src.f ====
verilog/dcore_pkg.sv
verilog/dcore_regs.sv
verilog/pam4_slicer.sv
verilog/sym_prbs_checker.sv
verilog/pi_ctl_mapper.sv
verilog/digital_core.sv
dv/digital_core_chk.sv
dv/tb_digital_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the digital core testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_digital_core -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0
